//--- filelist.f
+incdir+rtl
rtl/uop_pkg.sv
rtl/wb_pkg.sv
rtl/wb_result_select.sv
rtl/wb_trap_unit.sv
rtl/wb_commit.sv
rtl/wb_stage.sv
sim/tb_wb_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the writeback stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_wb_stage -f filelist.f -o tb_wb_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_wb_stage)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

//--- sim/tb_wb_stage.sv
`timescale 1ns/100ps
`include "wb_cfg.svh"

module tb_wb_stage;

    localparam int CLK_PERIOD  = 20;
    localparam int RAND_CYCLES = 400;
    localparam int SAME_CYCLES = 6;
    // reset, random, three stall cases, same rd, ten codes plus interrupt, gaps
    localparam int TEST_CYCLES = 8 + RAND_CYCLES + 3 * 4 + SAME_CYCLES + 11 + 10;

    logic             clk;
    logic             aresetn;
    wb_pkg::word_t    pc0, inst0, result0, pc1, inst1, result1;
    uop_pkg::uop_t    uop0, uop1;
    wb_pkg::reg_num_t rd0, rd1;
    logic             result_valid0, result_valid1;
    wb_pkg::word_t    quotient, remainder, dcache_data, csr_rdata;
    logic             div_ready, dcache_ready, csr_ready;
    logic             exception_in, cpu_interrupt;
    uop_pkg::ecode_t  ecode_in;
    wb_pkg::word_t    badv_in, era_in, eentry, tlbrentry;

    logic             wb_we0, wb_we1, allowin;
    wb_pkg::reg_num_t wb_rd0, wb_rd1;
    wb_pkg::word_t    wb_data0, wb_data1;
    wb_pkg::word_t    debug0_pc, debug0_inst, debug1_pc, debug1_inst;
    wb_pkg::rf_wen_t  debug0_wen, debug1_wen;
    logic             flush, wen_badv, wen_era, wen_vppn, tlb_refill;
    uop_pkg::ecode_t  ecode_out;
    wb_pkg::word_t    badv_out, era_out, redirect_pc;
    wb_pkg::vppn_t    vppn_out;

    // prediction for the pair driven at the last falling edge
    logic             exp_we0, exp_we1, exp_allowin, exp_trap;
    logic             exp_wen_badv, exp_wen_vppn, exp_tlb_refill;
    wb_pkg::word_t    exp_data0, exp_data1;

    integer           seed = 32'h36a6_2bad;
    bit               checking = 1'b0;
    int               n_checks = 0;
    int               n_errors = 0;
    int               test_base = 0;

    uop_pkg::ecode_t  codes [10] = '{uop_pkg::ECODE_INT, uop_pkg::ECODE_PIL,
        uop_pkg::ECODE_PIS, uop_pkg::ECODE_PIF, uop_pkg::ECODE_PME, uop_pkg::ECODE_PPI,
        uop_pkg::ECODE_ADEF, uop_pkg::ECODE_ALE, uop_pkg::ECODE_SYS, uop_pkg::ECODE_TLBR};

    wb_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    task automatic tally(input string name, input bit ok, input logic [31:0] got,
                         input logic [31:0] exp);
        n_checks++;
        if (!ok) begin
            n_errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input wb_pkg::word_t got,
                              input wb_pkg::word_t exp);
        tally(name, got === exp, got, exp);
    endtask

    task automatic check_reg(input string name, input wb_pkg::reg_num_t got,
                             input wb_pkg::reg_num_t exp);
        tally(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        tally(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_ecode(input string name, input uop_pkg::ecode_t got,
                               input uop_pkg::ecode_t exp);
        tally(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_wen(input string name, input wb_pkg::rf_wen_t got,
                             input wb_pkg::rf_wen_t exp);
        tally(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_vppn(input string name, input wb_pkg::vppn_t got,
                              input wb_pkg::vppn_t exp);
        tally(name, got === exp, 32'(got), 32'(exp));
    endtask

    // enables and trap flags that reset must clear
    task automatic verify_cleared_outputs();
        check_bit("wb_we0", wb_we0, 1'b0);
        check_bit("wb_we1", wb_we1, 1'b0);
        check_bit("wen_era", wen_era, 1'b0);
        check_bit("wen_badv", wen_badv, 1'b0);
        check_bit("wen_vppn", wen_vppn, 1'b0);
        check_bit("flush", flush, 1'b0);
        check_bit("tlb_refill", tlb_refill, 1'b0);
    endtask

    // one lane's writeback choice, highest priority first
    function automatic void lane_model(input uop_pkg::uop_t uop, input wb_pkg::word_t early,
                                       input logic early_valid, input bit csr_lane,
                                       output wb_pkg::word_t data, output logic we,
                                       output logic stall);
        logic slow;
        slow = 1'b1;
        data = '0;
        we = 1'b0;
        if (early_valid) begin
            slow = 1'b0;
            data = early;
            we = 1'b1;
        end else if (csr_lane && uop[`WB_UOP_CSR]) begin
            data = csr_rdata;
            we = csr_ready;
        end else if (uop[`WB_UOP_DIV]) begin
            data = uop[`WB_UOP_COND_LO + `WB_COND_REM] ? remainder : quotient;
            we = div_ready;
        end else if (uop[`WB_UOP_MEM] && !uop[`WB_UOP_COND_LO + `WB_COND_STORE]) begin
            data = dcache_data;
            we = dcache_ready;
        end else begin
            slow = 1'b0;
        end
        stall = slow && !we;
    endfunction

    function automatic void predict_pair();
        wb_pkg::word_t d0;
        wb_pkg::word_t d1;
        logic w0, w1, s0, s1;
        logic tlb_exc;
        lane_model(uop0, result0, result_valid0, 1'b1, d0, w0, s0);
        lane_model(uop1, result1, result_valid1, 1'b0, d1, w1, s1);
        exp_trap = exception_in || cpu_interrupt;
        // lane 1 is younger, so it owns a shared destination
        exp_we0 = w0 && !exp_trap && !(w1 && rd0 == rd1);
        exp_we1 = w1 && !exp_trap;
        exp_data0 = d0;
        exp_data1 = d1;
        exp_allowin = !(s0 || s1);
        tlb_exc = ecode_in inside {uop_pkg::ECODE_PIL, uop_pkg::ECODE_PIS, uop_pkg::ECODE_PIF,
                                   uop_pkg::ECODE_PME, uop_pkg::ECODE_PPI, uop_pkg::ECODE_TLBR};
        exp_wen_vppn = exception_in && tlb_exc;
        exp_wen_badv = exception_in && (tlb_exc || (ecode_in inside {uop_pkg::ECODE_ADEF,
                                                                      uop_pkg::ECODE_ALE}));
        exp_tlb_refill = exception_in && (ecode_in == uop_pkg::ECODE_TLBR);
        checking = 1'b1;
    endfunction

    // held inputs still describe the pair that was just registered
    always @(posedge clk) begin
        #(CLK_PERIOD / 4);
        if (checking) begin
            check_bit("allowin", allowin, exp_allowin);
            check_bit("wb_we0", wb_we0, exp_we0);
            check_bit("wb_we1", wb_we1, exp_we1);
            if (exp_we0) begin
                check_reg("wb_rd0", wb_rd0, rd0);
                check_word("wb_data0", wb_data0, exp_data0);
            end
            if (exp_we1) begin
                check_reg("wb_rd1", wb_rd1, rd1);
                check_word("wb_data1", wb_data1, exp_data1);
            end
            check_word("debug0_pc", debug0_pc, pc0);
            check_word("debug0_inst", debug0_inst, inst0);
            check_wen("debug0_wen", debug0_wen, {`WB_RF_WEN_W{exp_we0}});
            check_word("debug1_pc", debug1_pc, pc1);
            check_word("debug1_inst", debug1_inst, inst1);
            check_wen("debug1_wen", debug1_wen, {`WB_RF_WEN_W{exp_we1}});
            check_bit("flush", flush, exp_trap);
            check_bit("wen_era", wen_era, exp_trap);
            check_bit("wen_badv", wen_badv, exp_wen_badv);
            check_bit("wen_vppn", wen_vppn, exp_wen_vppn);
            check_bit("tlb_refill", tlb_refill, exp_tlb_refill);
            check_ecode("ecode_out", ecode_out, ecode_in);
            check_word("badv_out", badv_out, badv_in);
            check_word("era_out", era_out, era_in);
            check_vppn("vppn_out", vppn_out, badv_in[`WB_VPPN_W-1:0]);
            check_word("redirect_pc", redirect_pc, exp_tlb_refill ? tlbrentry : eentry);
        end
    end

    task automatic idle_inputs();
        uop0 = '0;
        uop1 = '0;
        result_valid0 = 1'b0;
        result_valid1 = 1'b0;
        div_ready = 1'b0;
        dcache_ready = 1'b0;
        csr_ready = 1'b0;
        exception_in = 1'b0;
        cpu_interrupt = 1'b0;
    endtask

    task automatic random_inputs();
        logic [31:0] r;
        logic [31:0] s;
        r = rnd();
        s = rnd();
        uop0 = r[7:0];
        uop1 = r[15:8];
        result_valid0 = (r[17:16] == 2'b00);
        result_valid1 = (r[19:18] == 2'b00);
        div_ready = r[20];
        dcache_ready = r[21];
        csr_ready = r[22];
        exception_in = (r[25:23] == 3'b000);
        cpu_interrupt = (r[29:26] == 4'b0000);
        rd0 = s[4:0];
        // a quarter of the pairs share a destination
        rd1 = (s[6:5] == 2'b00) ? s[4:0] : s[11:7];
        ecode_in = codes[s[15:12] % 4'd10];
        pc0 = rnd();
        inst0 = rnd();
        result0 = rnd();
        pc1 = rnd();
        inst1 = rnd();
        result1 = rnd();
        quotient = rnd();
        remainder = rnd();
        dcache_data = rnd();
        csr_rdata = rnd();
        badv_in = rnd();
        era_in = rnd();
        eentry = rnd();
        tlbrentry = rnd();
    endtask

    // source busy for three cycles, then its ready strobe
    task automatic stall_case(input uop_pkg::uop_t u0, input uop_pkg::uop_t u1);
        @(negedge clk);
        random_inputs();
        idle_inputs();
        uop0 = u0;
        uop1 = u1;
        repeat (3) begin
            predict_pair();
            @(negedge clk);
        end
        div_ready = 1'b1;
        dcache_ready = 1'b1;
        csr_ready = 1'b1;
        predict_pair();
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        #(CLK_PERIOD / 4 + 1);
        $display("test %s done, %0d errors", name, n_errors - test_base);
        test_base = n_errors;
    endtask

    initial begin
        random_inputs();
        idle_inputs();
        aresetn = 1'b0;
        // writes and tlb refill traps alternate while reset holds
        for (int i = 0; i < 8; i++) begin
            result_valid0 = 1'b1;
            result_valid1 = 1'b1;
            rd1 = rd0 + 5'd1;
            exception_in = i[0];
            ecode_in = uop_pkg::ECODE_TLBR;
            @(posedge clk);
            @(negedge clk);
            verify_cleared_outputs();
        end
        idle_inputs();
        aresetn = 1'b1;
        #1;
        verify_cleared_outputs();
        finish_test("reset values");

        repeat (RAND_CYCLES) begin
            @(negedge clk);
            random_inputs();
            predict_pair();
        end
        finish_test("random sources");

        // div remainder on lane 0, csr on lane 0, load on lane 1
        stall_case(8'h41, 8'h00);
        stall_case(8'h80, 8'h00);
        stall_case(8'h00, 8'h20);
        finish_test("stall and release");

        repeat (SAME_CYCLES) begin
            @(negedge clk);
            random_inputs();
            idle_inputs();
            result_valid0 = 1'b1;
            result_valid1 = 1'b1;
            rd1 = rd0;
            predict_pair();
        end
        finish_test("same destination");

        for (int i = 0; i < 11; i++) begin
            @(negedge clk);
            random_inputs();
            idle_inputs();
            result_valid0 = 1'b1;
            result_valid1 = 1'b1;
            // last pass is the interrupt alone
            if (i < 10) begin
                exception_in = 1'b1;
                ecode_in = codes[i];
            end else begin
                cpu_interrupt = 1'b1;
            end
            predict_pair();
        end
        finish_test("traps");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- rtl/wb_stage.sv
`timescale 1ns/100ps

module wb_stage (
    input  logic             clk,
    input  logic             aresetn,
    input  wb_pkg::word_t    pc0,
    input  wb_pkg::word_t    inst0,
    input  uop_pkg::uop_t    uop0,
    input  wb_pkg::reg_num_t rd0,
    input  wb_pkg::word_t    result0,
    input  logic             result_valid0,
    input  wb_pkg::word_t    pc1,
    input  wb_pkg::word_t    inst1,
    input  uop_pkg::uop_t    uop1,
    input  wb_pkg::reg_num_t rd1,
    input  wb_pkg::word_t    result1,
    input  logic             result_valid1,
    input  wb_pkg::word_t    quotient,
    input  wb_pkg::word_t    remainder,
    input  logic             div_ready,
    input  wb_pkg::word_t    dcache_data,
    input  logic             dcache_ready,
    input  wb_pkg::word_t    csr_rdata,
    input  logic             csr_ready,
    input  logic             exception_in,
    input  uop_pkg::ecode_t  ecode_in,
    input  wb_pkg::word_t    badv_in,
    input  wb_pkg::word_t    era_in,
    input  logic             cpu_interrupt,
    input  wb_pkg::word_t    eentry,
    input  wb_pkg::word_t    tlbrentry,
    output logic             wb_we0,
    output wb_pkg::reg_num_t wb_rd0,
    output wb_pkg::word_t    wb_data0,
    output logic             wb_we1,
    output wb_pkg::reg_num_t wb_rd1,
    output wb_pkg::word_t    wb_data1,
    output logic             allowin,
    output wb_pkg::word_t    debug0_pc,
    output wb_pkg::word_t    debug0_inst,
    output wb_pkg::rf_wen_t  debug0_wen,
    output wb_pkg::word_t    debug1_pc,
    output wb_pkg::word_t    debug1_inst,
    output wb_pkg::rf_wen_t  debug1_wen,
    output logic             flush,
    output uop_pkg::ecode_t  ecode_out,
    output wb_pkg::word_t    badv_out,
    output logic             wen_badv,
    output wb_pkg::word_t    era_out,
    output logic             wen_era,
    output wb_pkg::vppn_t    vppn_out,
    output logic             wen_vppn,
    output logic             tlb_refill,
    output wb_pkg::word_t    redirect_pc
);

    wb_pkg::word_t sel_data0;
    wb_pkg::word_t sel_data1;
    logic          sel_we0;
    logic          sel_we1;
    logic          stalled0;
    logic          stalled1;
    logic          trap_now;

    // only lane 0 can issue csr ops
    wb_result_select #(.csr_enable(1'b1)) u_sel0 (
        .uop(uop0), .result(result0), .result_valid(result_valid0),
        .csr_rdata(csr_rdata), .csr_ready(csr_ready),
        .quotient(quotient), .remainder(remainder), .div_ready(div_ready),
        .dcache_data(dcache_data), .dcache_ready(dcache_ready),
        .sel_data(sel_data0), .sel_we(sel_we0), .stalled(stalled0)
    );

    wb_result_select #(.csr_enable(1'b0)) u_sel1 (
        .uop(uop1), .result(result1), .result_valid(result_valid1),
        .csr_rdata(csr_rdata), .csr_ready(csr_ready),
        .quotient(quotient), .remainder(remainder), .div_ready(div_ready),
        .dcache_data(dcache_data), .dcache_ready(dcache_ready),
        .sel_data(sel_data1), .sel_we(sel_we1), .stalled(stalled1)
    );

    wb_trap_unit u_trap (
        .clk(clk), .aresetn(aresetn),
        .exception_in(exception_in), .ecode_in(ecode_in),
        .badv_in(badv_in), .era_in(era_in), .cpu_interrupt(cpu_interrupt),
        .eentry(eentry), .tlbrentry(tlbrentry),
        .trap_now(trap_now), .flush(flush), .ecode_out(ecode_out),
        .badv_out(badv_out), .wen_badv(wen_badv),
        .era_out(era_out), .wen_era(wen_era),
        .vppn_out(vppn_out), .wen_vppn(wen_vppn),
        .tlb_refill(tlb_refill), .redirect_pc(redirect_pc)
    );

    wb_commit u_commit (
        .clk(clk), .aresetn(aresetn), .trap_now(trap_now),
        .pc0(pc0), .inst0(inst0), .rd0(rd0),
        .sel_data0(sel_data0), .sel_we0(sel_we0), .stalled0(stalled0),
        .pc1(pc1), .inst1(inst1), .rd1(rd1),
        .sel_data1(sel_data1), .sel_we1(sel_we1), .stalled1(stalled1),
        .wb_we0(wb_we0), .wb_rd0(wb_rd0), .wb_data0(wb_data0),
        .wb_we1(wb_we1), .wb_rd1(wb_rd1), .wb_data1(wb_data1),
        .allowin(allowin),
        .debug0_pc(debug0_pc), .debug0_inst(debug0_inst), .debug0_wen(debug0_wen),
        .debug1_pc(debug1_pc), .debug1_inst(debug1_inst), .debug1_wen(debug1_wen)
    );

endmodule

//--- rtl/wb_commit.sv
`timescale 1ns/100ps

module wb_commit (
    input  logic             clk,
    input  logic             aresetn,
    input  logic             trap_now,
    input  wb_pkg::word_t    pc0,
    input  wb_pkg::word_t    inst0,
    input  wb_pkg::reg_num_t rd0,
    input  wb_pkg::word_t    sel_data0,
    input  logic             sel_we0,
    input  logic             stalled0,
    input  wb_pkg::word_t    pc1,
    input  wb_pkg::word_t    inst1,
    input  wb_pkg::reg_num_t rd1,
    input  wb_pkg::word_t    sel_data1,
    input  logic             sel_we1,
    input  logic             stalled1,
    output logic             wb_we0,
    output wb_pkg::reg_num_t wb_rd0,
    output wb_pkg::word_t    wb_data0,
    output logic             wb_we1,
    output wb_pkg::reg_num_t wb_rd1,
    output wb_pkg::word_t    wb_data1,
    output logic             allowin,
    output wb_pkg::word_t    debug0_pc,
    output wb_pkg::word_t    debug0_inst,
    output wb_pkg::rf_wen_t  debug0_wen,
    output wb_pkg::word_t    debug1_pc,
    output wb_pkg::word_t    debug1_inst,
    output wb_pkg::rf_wen_t  debug1_wen
);

    logic same_rd;
    logic commit_we0;
    logic commit_we1;

    // younger lane wins on a waw pair
    assign same_rd    = sel_we1 && (rd0 == rd1);
    assign commit_we0 = sel_we0 && !trap_now && !same_rd;
    assign commit_we1 = sel_we1 && !trap_now;

    // either lane waiting on a slow source holds the pair
    assign allowin = !(stalled0 || stalled1);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            wb_we0 <= 1'b0;
            wb_we1 <= 1'b0;
        end else begin
            wb_we0 <= commit_we0;
            wb_we1 <= commit_we1;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd0      <= rd0;
        wb_data0    <= sel_data0;
        wb_rd1      <= rd1;
        wb_data1    <= sel_data1;
        debug0_pc   <= pc0;
        debug0_inst <= inst0;
        debug1_pc   <= pc1;
        debug1_inst <= inst1;
    end

    // trace strobes follow the committed enables
    assign debug0_wen = {$bits(wb_pkg::rf_wen_t){wb_we0}};
    assign debug1_wen = {$bits(wb_pkg::rf_wen_t){wb_we1}};

    a_no_dual_write_same_rd: assert property (
        @(posedge clk) disable iff (!aresetn) (wb_we0 && wb_we1) |-> (wb_rd0 != wb_rd1)
    ) else $error("wb_commit: both ports write r%0d", wb_rd1);

endmodule

//--- rtl/wb_trap_unit.sv
`timescale 1ns/100ps
`include "wb_cfg.svh"

module wb_trap_unit (
    input  logic             clk,
    input  logic             aresetn,
    input  logic             exception_in,
    input  uop_pkg::ecode_t  ecode_in,
    input  wb_pkg::word_t    badv_in,
    input  wb_pkg::word_t    era_in,
    input  logic             cpu_interrupt,
    input  wb_pkg::word_t    eentry,
    input  wb_pkg::word_t    tlbrentry,
    output logic             trap_now,
    output logic             flush,
    output uop_pkg::ecode_t  ecode_out,
    output wb_pkg::word_t    badv_out,
    output logic             wen_badv,
    output wb_pkg::word_t    era_out,
    output logic             wen_era,
    output wb_pkg::vppn_t    vppn_out,
    output logic             wen_vppn,
    output logic             tlb_refill,
    output wb_pkg::word_t    redirect_pc
);

    logic set_badv;
    logic set_vppn;
    logic is_tlbr;

    assign trap_now = exception_in || cpu_interrupt;

    // address-carrying exceptions latch badv
    assign set_badv = ecode_in inside {uop_pkg::ECODE_PIL, uop_pkg::ECODE_PIS,
                                       uop_pkg::ECODE_PIF, uop_pkg::ECODE_PME,
                                       uop_pkg::ECODE_PPI, uop_pkg::ECODE_ADEF,
                                       uop_pkg::ECODE_ALE, uop_pkg::ECODE_TLBR};

    // tlb related only, address errors leave vppn alone
    assign set_vppn = set_badv && (ecode_in != uop_pkg::ECODE_ADEF)
                               && (ecode_in != uop_pkg::ECODE_ALE);

    assign is_tlbr = (ecode_in == uop_pkg::ECODE_TLBR);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            flush      <= 1'b0;
            wen_era    <= 1'b0;
            wen_badv   <= 1'b0;
            wen_vppn   <= 1'b0;
            tlb_refill <= 1'b0;
        end else begin
            flush      <= trap_now;
            wen_era    <= trap_now;
            wen_badv   <= exception_in && set_badv;
            wen_vppn   <= exception_in && set_vppn;
            tlb_refill <= exception_in && is_tlbr;
        end
    end

    always_ff @(posedge clk) begin
        ecode_out <= ecode_in;
        badv_out  <= badv_in;
        era_out   <= era_in;
        vppn_out  <= badv_in[`WB_VPPN_W-1:0];
    end

    // refill goes to the dedicated handler
    assign redirect_pc = tlb_refill ? tlbrentry : eentry;

    a_vppn_needs_badv: assert property (
        @(posedge clk) disable iff (!aresetn) wen_vppn |-> wen_badv
    ) else $error("wb_trap_unit: vppn update without badv update");

endmodule

//--- rtl/wb_result_select.sv
`timescale 1ns/100ps
`include "wb_cfg.svh"

module wb_result_select #(
    parameter bit csr_enable = 1'b0
) (
    input  uop_pkg::uop_t uop,
    input  wb_pkg::word_t result,
    input  logic          result_valid,
    input  wb_pkg::word_t csr_rdata,
    input  logic          csr_ready,
    input  wb_pkg::word_t quotient,
    input  wb_pkg::word_t remainder,
    input  logic          div_ready,
    input  wb_pkg::word_t dcache_data,
    input  logic          dcache_ready,
    output wb_pkg::word_t sel_data,
    output logic          sel_we,
    output logic          stalled
);

    uop_pkg::uop_cond_t cond;

    assign cond = uop[`WB_UOP_COND_HI:`WB_UOP_COND_LO];

    always_comb begin
        sel_data = '0;
        sel_we   = 1'b0;
        stalled  = 1'b0;

        if (result_valid) begin
            // alu, mul and branch link results arrive early
            sel_data = result;
            sel_we   = 1'b1;
        end else if (csr_enable && uop[`WB_UOP_CSR]) begin
            sel_data = csr_rdata;
            sel_we   = csr_ready;
            stalled  = !csr_ready;
        end else if (uop[`WB_UOP_DIV]) begin
            // mod vs div
            if (cond[`WB_COND_REM]) begin
                sel_data = remainder;
            end else begin
                sel_data = quotient;
            end
            sel_we  = div_ready;
            stalled = !div_ready;
        end else if (uop[`WB_UOP_MEM] && !cond[`WB_COND_STORE]) begin
            // loads only, stores have no destination
            sel_data = dcache_data;
            sel_we   = dcache_ready;
            stalled  = !dcache_ready;
        end

        a_no_we_while_stalled: assert (!(sel_we && stalled))
            else $error("wb_result_select: write enable raised while stalled");
    end

endmodule

//--- rtl/wb_pkg.sv
`include "wb_cfg.svh"

package wb_pkg;

    // architectural data word
    typedef logic [`WB_XLEN-1:0] word_t;

    // gpr index
    typedef logic [`WB_RA_W-1:0] reg_num_t;

    // virtual page number slice of badv
    typedef logic [`WB_VPPN_W-1:0] vppn_t;

    // byte strobes on the trace port
    typedef logic [`WB_RF_WEN_W-1:0] rf_wen_t;

endpackage

//--- rtl/uop_pkg.sv
`include "wb_cfg.svh"

package uop_pkg;

    // one word per issued micro-op
    typedef logic [`WB_UOP_W-1:0] uop_t;

    // low bits of the uop, meaning depends on the unit
    typedef logic [`WB_UOP_COND_HI-`WB_UOP_COND_LO:0] uop_cond_t;

    typedef enum logic [`WB_ECODE_W-1:0] {
        // interrupt, only ever raised through cpu_interrupt
        ECODE_INT  = `WB_ECODE_INT,
        // page invalid for load, store, fetch
        ECODE_PIL  = `WB_ECODE_PIL,
        ECODE_PIS  = `WB_ECODE_PIS,
        ECODE_PIF  = `WB_ECODE_PIF,
        // page modify
        ECODE_PME  = `WB_ECODE_PME,
        // page privilege
        ECODE_PPI  = `WB_ECODE_PPI,
        // fetch and data address errors
        ECODE_ADEF = `WB_ECODE_ADEF,
        ECODE_ALE  = `WB_ECODE_ALE,
        // syscall
        ECODE_SYS  = `WB_ECODE_SYS,
        // tlb refill, uses its own entry
        ECODE_TLBR = `WB_ECODE_TLBR
    } ecode_t;

endpackage

//--- rtl/wb_cfg.svh
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// datapath widths
`define WB_XLEN     32
`define WB_RA_W     5
`define WB_VPPN_W   19
`define WB_RF_WEN_W 4

// micro-op vector layout
`define WB_UOP_W       8
`define WB_UOP_CSR     7
`define WB_UOP_DIV     6
`define WB_UOP_MEM     5
`define WB_UOP_COND_HI 3
`define WB_UOP_COND_LO 0

// condition field bits, relative to the field
`define WB_COND_REM   0
`define WB_COND_STORE 2

// exception codes
`define WB_ECODE_W    7
`define WB_ECODE_INT  7'h00
`define WB_ECODE_PIL  7'h01
`define WB_ECODE_PIS  7'h02
`define WB_ECODE_PIF  7'h03
`define WB_ECODE_PME  7'h04
`define WB_ECODE_PPI  7'h07
`define WB_ECODE_ADEF 7'h08
`define WB_ECODE_ALE  7'h09
`define WB_ECODE_SYS  7'h0B
`define WB_ECODE_TLBR 7'h3F

`endif
